// ==== hdl/ddc_pkg.sv ====
`default_nettype none

package ddc_pkg;

    // ====================================================================
    // Widths and pipeline depths
    // ====================================================================
    localparam int SAMPLE_W      = 16;
    localparam int PHASE_W       = 32;
    localparam int LUT_ADDR_W    = 8;
    localparam int LUT_DEPTH     = 2 ** LUT_ADDR_W;
    localparam int LUT_QUARTER   = LUT_DEPTH / 4;    // 90 degrees in table steps.
    localparam int COEF_W        = 16;
    localparam int COEF_MAX      = 32767;
    localparam int FRAC_BITS     = 15;
    localparam int HB_SHIFT      = 5;
    localparam int HB_SUM_W      = SAMPLE_W + 6;     // Absolute tap sum is 36.
    localparam int MIXER_LATENCY = 3;
    localparam int HB_LATENCY    = 2;
    localparam real PI           = 3.14159265358979323846;

    typedef logic signed [SAMPLE_W-1:0]        sample_t;
    typedef logic        [PHASE_W-1:0]         phase_t;
    typedef logic signed [COEF_W-1:0]          coef_t;
    typedef logic signed [SAMPLE_W+COEF_W-1:0] product_t;
    typedef logic signed [HB_SUM_W-1:0]        hb_sum_t;
    typedef logic        [LUT_ADDR_W-1:0]      lut_addr_t;
    typedef coef_t                             cos_lut_t [LUT_DEPTH];

    localparam sample_t SAMPLE_MAX = sample_t'(2 ** (SAMPLE_W - 1) - 1);
    localparam sample_t SAMPLE_MIN = sample_t'(-(2 ** (SAMPLE_W - 1)));

    typedef struct packed {
        sample_t early;    // Earlier sample of the pair.
        sample_t late;
    } sample_pair_t;

    typedef struct packed {
        coef_t cos;
        coef_t sin;
    } trig_t;

    typedef struct packed {
        trig_t early;
        trig_t late;
    } nco_pair_t;

    typedef struct packed {
        sample_t i;
        sample_t q;
    } iq_t;

    // ====================================================================
    // Shared functions
    // ====================================================================
    function automatic cos_lut_t cos_table();
        cos_lut_t lut;
        real      angle;
        for (int k = 0; k < LUT_DEPTH; k++) begin
            angle  = 2.0 * PI * real'(k) / real'(LUT_DEPTH);
            lut[k] = coef_t'(int'(real'(COEF_MAX) * $cos(angle)));    // int' rounds.
        end
        return lut;
    endfunction

    function automatic sample_t saturate(input longint value);
        if (value > longint'(SAMPLE_MAX)) begin
            return SAMPLE_MAX;
        end
        if (value < longint'(SAMPLE_MIN)) begin
            return SAMPLE_MIN;
        end
        return sample_t'(value);
    endfunction

endpackage

`default_nettype wire

// ==== hdl/ddc_nco.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddc_nco (
    input  wire logic               i_clock,
    input  wire logic               i_rst_n,
    input  wire logic               i_valid,
    input  wire ddc_pkg::phase_t    i_phase_inc,
    input  wire logic               i_phase_inc_valid,
    output      ddc_pkg::nco_pair_t o_trig,
    output      logic               o_valid
);

    import ddc_pkg::*;

    localparam cos_lut_t COS_LUT = cos_table();

    phase_t phase_inc;
    phase_t phase_acc;
    phase_t phase_late;

    // Top phase bits address the table; sine reads a quarter turn back.
    function automatic trig_t lookup(input phase_t phase);
        lut_addr_t idx;
        trig_t     trig;
        idx      = phase[PHASE_W-1 -: LUT_ADDR_W];
        trig.cos = COS_LUT[idx];
        trig.sin = COS_LUT[lut_addr_t'(idx - LUT_QUARTER)];
        return trig;
    endfunction

    assign phase_late = phase_acc + phase_inc;    // Second sample of the pair.

    // ====================================================================
    // Phase accumulator
    // ====================================================================
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase_inc <= '0;
            phase_acc <= '0;
        end else if (i_phase_inc_valid) begin
            phase_inc <= i_phase_inc;
            phase_acc <= '0;                                   // Restart at phase zero.
        end else if (i_valid) begin
            phase_acc <= phase_acc + (phase_inc << 1);         // Two samples per pair.
        end
    end

    // ====================================================================
    // Registered lookups
    // ====================================================================
    always_ff @(posedge i_clock) begin
        o_trig.early <= lookup(phase_acc);
        o_trig.late  <= lookup(phase_late);
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    nco_valid_delay_a: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        o_valid == $past(i_valid)
    ) else $error("NCO valid is not the input valid delayed by one cycle.");

endmodule

`default_nettype wire

// ==== hdl/ddc_mixer_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddc_mixer_lane (
    input  wire logic             i_clock,
    input  wire logic             i_rst_n,
    input  wire ddc_pkg::sample_t i_sample,
    input  wire logic             i_valid,
    input  wire ddc_pkg::trig_t   i_trig,
    output      ddc_pkg::iq_t     o_iq,
    output      logic             o_valid
);

    import ddc_pkg::*;

    localparam product_t MIX_RND = product_t'(1) <<< (FRAC_BITS - 1);

    sample_t  sample_q;
    product_t prod_i;
    product_t prod_q;
    logic     valid_q;
    logic     valid_p;

    // ====================================================================
    // Datapath
    // ====================================================================
    always_ff @(posedge i_clock) begin
        sample_q <= i_sample;                                  // Lines up with the NCO.
        prod_i   <= sample_q * i_trig.cos;
        prod_q   <= sample_q * i_trig.sin;
        o_iq.i   <= saturate(longint'((prod_i + MIX_RND) >>> FRAC_BITS));
        o_iq.q   <= saturate(longint'((prod_q + MIX_RND) >>> FRAC_BITS));
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
            valid_p <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            valid_q <= i_valid;
            valid_p <= valid_q;
            o_valid <= valid_p;
        end
    end

    mixer_latency_a: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        o_valid == $past(i_valid, MIXER_LATENCY)
    ) else $error("Mixer valid is off its fixed latency.");

endmodule

`default_nettype wire

// ==== hdl/ddc_halfband_decim.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddc_halfband_decim (
    input  wire logic         i_clock,
    input  wire logic         i_rst_n,
    input  wire ddc_pkg::iq_t i_early,
    input  wire ddc_pkg::iq_t i_late,
    input  wire logic         i_valid,
    output      ddc_pkg::iq_t o_iq,
    output      logic         o_valid
);

    import ddc_pkg::*;

    localparam hb_sum_t HB_RND = hb_sum_t'(1) <<< (HB_SHIFT - 1);

    iq_t     early_hist [3];    // Early samples m-1, m-2, m-3.
    iq_t     late_hist  [2];    // Late samples m-1, m-2.
    hb_sum_t sum_i;
    hb_sum_t sum_q;
    logic    valid_s1;

    // Taps -1, 9, 9, -1 on the early phase and 16 on the late phase.
    function automatic hb_sum_t hb_sum(
        input sample_t a0,
        input sample_t a1,
        input sample_t a2,
        input sample_t a3,
        input sample_t b2
    );
        hb_sum_t mid;
        mid = hb_sum_t'(a1) + hb_sum_t'(a2);
        return (mid <<< 3) + mid - hb_sum_t'(a0) - hb_sum_t'(a3) + (hb_sum_t'(b2) <<< 4);
    endfunction

    // ====================================================================
    // Stage 1: history and weighted sum
    // ====================================================================
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            early_hist[0] <= '0;
            early_hist[1] <= '0;
            early_hist[2] <= '0;
            late_hist[0]  <= '0;
            late_hist[1]  <= '0;
        end else if (i_valid) begin
            early_hist[0] <= i_early;
            early_hist[1] <= early_hist[0];
            early_hist[2] <= early_hist[1];
            late_hist[0]  <= i_late;
            late_hist[1]  <= late_hist[0];
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_valid) begin
            sum_i <= hb_sum(i_early.i, early_hist[0].i, early_hist[1].i,
                            early_hist[2].i, late_hist[1].i);
            sum_q <= hb_sum(i_early.q, early_hist[0].q, early_hist[1].q,
                            early_hist[2].q, late_hist[1].q);
        end
    end

    // ====================================================================
    // Stage 2: round and saturate
    // ====================================================================
    always_ff @(posedge i_clock) begin
        o_iq.i <= saturate(longint'((sum_i + HB_RND) >>> HB_SHIFT));
        o_iq.q <= saturate(longint'((sum_q + HB_RND) >>> HB_SHIFT));
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_s1 <= 1'b0;
            o_valid  <= 1'b0;
        end else begin
            valid_s1 <= i_valid;
            o_valid  <= valid_s1;
        end
    end

    // One output per input pair, never one out of nothing.
    hb_no_spurious_a: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        !$past(i_valid, HB_LATENCY) |-> !o_valid
    ) else $error("Decimator produced an output without an input pair.");

endmodule

`default_nettype wire

// ==== hdl/ddc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddc_top (
    input  wire logic                  i_clock,
    input  wire logic                  i_rst_n,
    input  wire ddc_pkg::sample_pair_t i_sample,
    input  wire logic                  i_valid,
    input  wire ddc_pkg::phase_t       i_phase_inc,
    input  wire logic                  i_phase_inc_valid,
    output      ddc_pkg::iq_t          o_iq,
    output      logic                  o_valid
);

    import ddc_pkg::*;

    nco_pair_t nco_trig;
    iq_t       early_iq;
    iq_t       late_iq;
    logic      early_valid;

    ddc_nco nco_i (
        .i_clock          (i_clock),
        .i_rst_n          (i_rst_n),
        .i_valid          (i_valid),
        .i_phase_inc      (i_phase_inc),
        .i_phase_inc_valid(i_phase_inc_valid),
        .o_trig           (nco_trig),
        .o_valid          ()                 // Lanes keep their own valid pipe.
    );

    ddc_mixer_lane mixer_early_i (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_sample(i_sample.early),
        .i_valid (i_valid),
        .i_trig  (nco_trig.early),
        .o_iq    (early_iq),
        .o_valid (early_valid)
    );

    ddc_mixer_lane mixer_late_i (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .i_sample(i_sample.late),
        .i_valid (i_valid),
        .i_trig  (nco_trig.late),
        .o_iq    (late_iq),
        .o_valid ()                          // Same as the early lane's valid.
    );

    ddc_halfband_decim halfband_i (
        .i_clock(i_clock),
        .i_rst_n(i_rst_n),
        .i_early(early_iq),
        .i_late (late_iq),
        .i_valid(early_valid),
        .o_iq   (o_iq),
        .o_valid(o_valid)
    );

endmodule

`default_nettype wire

// ==== dv/ddc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddc_tb;

    import ddc_pkg::*;

    localparam int RESET_CYCLES  = 4;
    localparam int IDLE_CYCLES   = 20;
    localparam int DC_PAIRS      = 12;
    localparam int QR_PAIRS      = 40;
    localparam int SAT_PAIRS     = 8;
    localparam int FLUSH_PAIRS   = 3;     // Clears the halfband history.
    localparam int GAP_PAIRS     = 24;
    localparam int MAX_GAP       = 3;
    localparam int RELOAD_PAIRS  = 10;
    localparam int NUM_RELOADS   = 7;
    localparam int NUM_DRAINS    = 8;
    localparam int DRAIN_CYCLES  = 10;
    localparam int LATENCY       = 5;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + DC_PAIRS + QR_PAIRS + SAT_PAIRS
                                 + 2 * (FLUSH_PAIRS + GAP_PAIRS) + GAP_PAIRS * MAX_GAP
                                 + 2 * RELOAD_PAIRS + 2 * NUM_RELOADS
                                 + DRAIN_CYCLES * NUM_DRAINS;
    localparam int TIMEOUT_LIMIT = TOTAL_CYCLES + 50;
    localparam sample_t FS_POS   = 16'h7FFF;
    localparam sample_t FS_NEG   = 16'h8000;
    localparam real TWO_PI       = 6.28318530717958647692;

    logic         i_clock;
    logic         i_rst_n;
    sample_pair_t i_sample;
    logic         i_valid;
    phase_t       i_phase_inc;
    logic         i_phase_inc_valid;
    iq_t          o_iq;
    logic         o_valid;

    coef_t        tb_cos [256];
    phase_t       m_inc;
    phase_t       m_acc;
    iq_t          m_early [3];    // Early mixed values m-1, m-2, m-3.
    iq_t          m_late  [2];
    iq_t          exp_q [$];
    int           issue_q [$];
    iq_t          got_q [$];
    iq_t          ref_q [$];
    sample_pair_t gap_pairs [$];
    logic [31:0]  lfsr_state = 32'd84329;
    int           cycle_count  = 0;
    int           out_count    = 0;
    int           pair_count   = 0;
    int           value_errors = 0;
    int           other_errors = 0;
    int           clamp_hi     = 0;
    int           clamp_lo     = 0;
    bit           capture_on   = 1'b0;

    ddc_top dut_i (
        .i_clock          (i_clock),
        .i_rst_n          (i_rst_n),
        .i_sample         (i_sample),
        .i_valid          (i_valid),
        .i_phase_inc      (i_phase_inc),
        .i_phase_inc_valid(i_phase_inc_valid),
        .o_iq             (o_iq),
        .o_valid          (o_valid)
    );

    initial begin
        i_clock = 1'b0;
        forever #50 i_clock = ~i_clock;
    end

    always @(posedge i_clock) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= TIMEOUT_LIMIT);
        $display("Timeout: the run went past %0d cycles", TIMEOUT_LIMIT);
        $display("Checks failed");
        $finish;
    end

    // ====================================================================
    // Stimulus helpers and reference model
    // ====================================================================
    function automatic logic lfsr_bit();
        logic fb;
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};    // Taps 32, 22, 2, 1.
        return fb;
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        repeat (n) v = {v[14:0], lfsr_bit()};
        return v;
    endfunction

    function automatic void build_table();
        real v;
        for (int k = 0; k < 256; k++) begin
            v         = 32767.0 * $cos(TWO_PI * k / 256.0);
            tb_cos[k] = (v >= 0.0) ? coef_t'($rtoi(v + 0.5)) : coef_t'(-$rtoi(0.5 - v));
        end
    endfunction

    function automatic sample_t clamp16(input longint v);
        if (v > 32767) return FS_POS;
        if (v < -32768) return FS_NEG;
        return sample_t'(v);
    endfunction

    function automatic iq_t mix(input sample_t s, input phase_t phase);
        int     k;
        longint pi_l;
        longint pq_l;
        iq_t    r;
        k    = phase[31:24];
        pi_l = longint'(s) * longint'(tb_cos[k]);
        pq_l = longint'(s) * longint'(tb_cos[(k + 192) % 256]);    // Quarter turn back.
        r.i  = clamp16((pi_l + 16384) >>> 15);
        r.q  = clamp16((pq_l + 16384) >>> 15);
        return r;
    endfunction

    function automatic sample_t halfband(input longint a0, input longint a1,
                                         input longint a2, input longint a3,
                                         input longint b2);
        longint v;
        v = (-a0 + 9 * a1 + 9 * a2 - a3 + 16 * b2 + 16) >>> 5;
        return clamp16(v);
    endfunction

    task automatic model_pair(input sample_pair_t p);
        iq_t a;
        iq_t b;
        iq_t y;
        a   = mix(p.early, m_acc);
        b   = mix(p.late, m_acc + m_inc);
        y.i = halfband(a.i, m_early[0].i, m_early[1].i, m_early[2].i, m_late[1].i);
        y.q = halfband(a.q, m_early[0].q, m_early[1].q, m_early[2].q, m_late[1].q);
        exp_q.push_back(y);
        m_early[2] = m_early[1];
        m_early[1] = m_early[0];
        m_early[0] = a;
        m_late[1]  = m_late[0];
        m_late[0]  = b;
        m_acc      = m_acc + (m_inc << 1);
    endtask

    task automatic drive_pair(input sample_pair_t p);
        @(negedge i_clock);
        i_sample = p;
        i_valid  = 1'b1;
        issue_q.push_back(cycle_count);
        pair_count++;
        model_pair(p);
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(negedge i_clock);
            i_valid = 1'b0;
        end
    endtask

    task automatic reload_inc(input phase_t inc);
        @(negedge i_clock);
        i_valid           = 1'b0;
        i_phase_inc       = inc;
        i_phase_inc_valid = 1'b1;
        m_inc             = inc;
        m_acc             = '0;
        @(negedge i_clock);
        i_phase_inc_valid = 1'b0;
    endtask

    task automatic wait_drain();
        drive_idle(1);
        while (exp_q.size() > 0) @(negedge i_clock);
        drive_idle(2);
    endtask

    // ====================================================================
    // Compare tasks and output monitor
    // ====================================================================
    task automatic check_iq(input string name, input iq_t got, input iq_t exp);
        if (got.i !== exp.i) begin
            value_errors++;
            $display("FAILED %s.i: got %h expected %h", name, got.i, exp.i);
        end
        if (got.q !== exp.q) begin
            value_errors++;
            $display("FAILED %s.q: got %h expected %h", name, got.q, exp.q);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            value_errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    always @(negedge i_clock) begin
        if (i_rst_n && o_valid) begin
            out_count++;
            if (o_iq.i === FS_POS) begin
                clamp_hi++;
            end
            if (o_iq.i === FS_NEG) begin
                clamp_lo++;
            end
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("An output appeared with no input pair pending");
            end else begin
                check_iq("o_iq", o_iq, exp_q.pop_front());
                check_count("latency", cycle_count - issue_q.pop_front(), LATENCY);
                if (capture_on) got_q.push_back(o_iq);
            end
        end
    end

    // ====================================================================
    // Directed tests
    // ====================================================================
    task automatic test_idle();
        drive_idle(IDLE_CYCLES);
        check_count("outputs while idle", out_count, 0);
    endtask

    task automatic test_dc();
        sample_pair_t p;
        p.early = 16'sd12000;
        p.late  = 16'sd12000;
        reload_inc('0);                         // cos stays at 32767, sin at 0.
        repeat (DC_PAIRS) drive_pair(p);
        wait_drain();
    endtask

    task automatic test_quarter_rate();
        sample_pair_t p;
        reload_inc(32'h4000_0000);
        repeat (QR_PAIRS) begin
            p.early = sample_t'(rand_bits(16));
            p.late  = sample_t'(rand_bits(16));
            drive_pair(p);
        end
        wait_drain();
    endtask

    task automatic test_saturation();
        sample_pair_t p;
        logic [7:0]   early_pos;
        logic [7:0]   late_pos;
        early_pos = 8'b1001_0110;               // Pairs 3 and 7 clamp high and low.
        late_pos  = 8'b0000_1111;
        clamp_hi  = 0;
        clamp_lo  = 0;
        reload_inc('0);
        for (int m = 0; m < SAT_PAIRS; m++) begin
            p.early = early_pos[m] ? FS_POS : FS_NEG;
            p.late  = late_pos[m] ? FS_POS : FS_NEG;
            drive_pair(p);
        end
        wait_drain();
        if (clamp_hi == 0 || clamp_lo == 0) begin
            other_errors++;
            $display("The DUT outputs of the full-scale pattern did not reach both limits");
        end
    endtask

    task automatic run_gap_pass(input bit idle_between);
        sample_pair_t zero_pair;
        zero_pair = '0;
        reload_inc(32'h1999_999A);
        repeat (FLUSH_PAIRS) drive_pair(zero_pair);
        wait_drain();
        got_q.delete();
        capture_on = 1'b1;
        foreach (gap_pairs[n]) begin
            drive_pair(gap_pairs[n]);
            if (idle_between) drive_idle(int'(rand_bits(2)));
        end
        wait_drain();
        capture_on = 1'b0;
    endtask

    task automatic test_gaps();
        sample_pair_t p;
        repeat (GAP_PAIRS) begin
            p.early = sample_t'(rand_bits(16));
            p.late  = sample_t'(rand_bits(16));
            gap_pairs.push_back(p);
        end
        run_gap_pass(1'b0);
        ref_q = got_q;
        run_gap_pass(1'b1);
        check_count("gap-free run outputs", ref_q.size(), GAP_PAIRS);
        check_count("gapped run outputs", got_q.size(), GAP_PAIRS);
        for (int n = 0; n < got_q.size() && n < ref_q.size(); n++) begin
            check_iq("gapped o_iq", got_q[n], ref_q[n]);
        end
    endtask

    task automatic test_reload();
        sample_pair_t p;
        reload_inc(32'h1234_5678);
        repeat (RELOAD_PAIRS) begin
            p.early = sample_t'(rand_bits(16));
            p.late  = sample_t'(rand_bits(16));
            drive_pair(p);
        end
        reload_inc(32'h0ABC_DEF0);             // Earlier pairs still in flight.
        repeat (RELOAD_PAIRS) begin
            p.early = sample_t'(rand_bits(16));
            p.late  = sample_t'(rand_bits(16));
            drive_pair(p);
        end
        wait_drain();
    endtask

    initial begin
        i_rst_n           = 1'b0;
        i_sample          = '0;
        i_valid           = 1'b0;
        i_phase_inc       = '0;
        i_phase_inc_valid = 1'b0;
        m_inc             = '0;
        m_acc             = '0;
        m_early           = '{default: '0};
        m_late            = '{default: '0};
        build_table();
        repeat (RESET_CYCLES) @(negedge i_clock);
        i_rst_n = 1'b1;
        test_idle();
        test_dc();
        test_quarter_rate();
        test_saturation();
        test_gaps();
        test_reload();
        check_count("total outputs", out_count, pair_count);
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/ddc_pkg.sv
hdl/ddc_nco.sv
hdl/ddc_mixer_lane.sv
hdl/ddc_halfband_decim.sv
hdl/ddc_top.sv
dv/ddc_tb.sv

// ==== Bender.yml ====
package:
  name: ddc

sources:
  - hdl/ddc_pkg.sv
  - hdl/ddc_nco.sv
  - hdl/ddc_mixer_lane.sv
  - hdl/ddc_halfband_decim.sv
  - hdl/ddc_top.sv
  - target: test
    files:
      - dv/ddc_tb.sv
